// File: hw/mips_pkg.sv
package mips_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int data_w     = 32; // one word, also the address width.
  localparam int reg_addr_w = 5;  // 32 architectural registers.

  localparam logic [reg_addr_w-1:0] link_reg = 5'd31; // $ra.

  // ~~~~~~~~~~~~~~~~~~~~
  // encodings
  // ~~~~~~~~~~~~~~~~~~~~

  // primary opcode, inst[31:26].
  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_regimm  = 6'h01,
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_blez    = 6'h06,
    op_bgtz    = 6'h07
  } opcode_t;

  // special function field, inst[5:0].
  typedef enum logic [5:0] {
    funct_jr   = 6'h08,
    funct_jalr = 6'h09
  } funct_t;

  // regimm rt field, inst[20:16].
  typedef enum logic [4:0] {
    rt_bltz   = 5'h00,
    rt_bgez   = 5'h01,
    rt_bltzal = 5'h10,
    rt_bgezal = 5'h11
  } regimm_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // decoded branch class
  // ~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [3:0] {
    br_none, // not a control transfer.
    br_jump, // absolute 26-bit index in the current region.
    br_jreg, // target taken from rs.
    br_eq,   // rs == rt.
    br_ne,   // rs != rt.
    br_gtz,  // rs > 0, signed.
    br_lez,  // rs <= 0, signed.
    br_ltz,  // rs < 0, signed.
    br_gez   // rs >= 0, signed.
  } branch_kind_t;

endpackage

// File: hw/branch_decoder.sv
module branch_decoder (
  input  logic [31:0]                       inst,
  output mips_pkg::branch_kind_t            branch_kind,
  output logic                              link_en,
  output logic [mips_pkg::reg_addr_w-1:0]   link_addr
);

  mips_pkg::opcode_t               op;
  mips_pkg::funct_t                funct;
  mips_pkg::regimm_t               rt_code;
  logic [mips_pkg::reg_addr_w-1:0] rd;

  // ~~~~~~~~~~~~~~~~~~~~
  // field split
  // ~~~~~~~~~~~~~~~~~~~~

  assign op      = mips_pkg::opcode_t'(inst[31:26]);
  assign funct   = mips_pkg::funct_t'(inst[5:0]);
  assign rt_code = mips_pkg::regimm_t'(inst[20:16]);
  assign rd      = inst[15:11];

  // ~~~~~~~~~~~~~~~~~~~~
  // classify
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    branch_kind = mips_pkg::br_none;
    link_en     = 1'b0;
    link_addr   = mips_pkg::link_reg; // $ra unless jalr names rd.

    case (op)
      mips_pkg::op_j: begin
        branch_kind = mips_pkg::br_jump;
      end
      mips_pkg::op_jal: begin
        branch_kind = mips_pkg::br_jump;
        link_en     = 1'b1;
      end
      mips_pkg::op_special: begin
        case (funct)
          mips_pkg::funct_jr: begin
            branch_kind = mips_pkg::br_jreg;
          end
          mips_pkg::funct_jalr: begin
            branch_kind = mips_pkg::br_jreg;
            link_en     = 1'b1;
            link_addr   = rd;
          end
          default: ; // alu ops, not handled here.
        endcase
      end
      mips_pkg::op_beq: begin
        branch_kind = mips_pkg::br_eq;
      end
      mips_pkg::op_bne: begin
        branch_kind = mips_pkg::br_ne;
      end
      mips_pkg::op_blez: begin
        branch_kind = mips_pkg::br_lez;
      end
      mips_pkg::op_bgtz: begin
        branch_kind = mips_pkg::br_gtz;
      end
      mips_pkg::op_regimm: begin
        case (rt_code)
          mips_pkg::rt_bltz: begin
            branch_kind = mips_pkg::br_ltz;
          end
          mips_pkg::rt_bgez: begin
            branch_kind = mips_pkg::br_gez;
          end
          mips_pkg::rt_bltzal: begin
            branch_kind = mips_pkg::br_ltz;
            link_en     = 1'b1; // links even when not taken.
          end
          mips_pkg::rt_bgezal: begin
            branch_kind = mips_pkg::br_gez;
            link_en     = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;
    endcase

    // a link only comes with some control transfer.
    assert (!(link_en && branch_kind == mips_pkg::br_none))
      else $error("branch_decoder: link without branch, inst %h", inst);
  end

endmodule

// File: hw/reg_file.sv
module reg_file (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [mips_pkg::reg_addr_w-1:0]   rs_addr,
  input  logic [mips_pkg::reg_addr_w-1:0]   rt_addr,
  output logic [mips_pkg::data_w-1:0]       rs_data,
  output logic [mips_pkg::data_w-1:0]       rt_data,
  input  logic                              wr_en,
  input  logic [mips_pkg::reg_addr_w-1:0]   wr_addr,
  input  logic [mips_pkg::data_w-1:0]       wr_data,
  input  logic                              link_en,
  input  logic [mips_pkg::reg_addr_w-1:0]   link_addr,
  input  logic [mips_pkg::data_w-1:0]       link_data
);

  localparam int n_regs = 1 << mips_pkg::reg_addr_w;

  logic [mips_pkg::data_w-1:0] regs [1:n_regs-1]; // no storage for $zero.

  // ~~~~~~~~~~~~~~~~~~~~
  // write ports
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < n_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < n_regs; i++) begin
        if (link_en && link_addr == i[mips_pkg::reg_addr_w-1:0]) begin
          regs[i] <= link_data; // link beats write-back.
        end else if (wr_en && wr_addr == i[mips_pkg::reg_addr_w-1:0]) begin
          regs[i] <= wr_data;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // read ports
  // ~~~~~~~~~~~~~~~~~~~~

  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

  // a write aimed at $zero must leave it reading zero next cycle.
  a_zero_never_written: assert property (
    @(posedge clk) disable iff (rst)
    ((wr_en && wr_addr == '0) || (link_en && link_addr == '0)) ##1 (rs_addr == '0)
      |-> (rs_data == '0)
  ) else $error("reg_file: register zero changed after a write");

endmodule

// File: hw/branch_gen.sv
module branch_gen (
  input  logic [mips_pkg::data_w-1:0]   pc,
  input  logic [31:0]                   inst,
  input  mips_pkg::branch_kind_t        branch_kind,
  input  logic [mips_pkg::data_w-1:0]   rs_data,
  input  logic [mips_pkg::data_w-1:0]   rt_data,
  output logic                          branch_flag,
  output logic [mips_pkg::data_w-1:0]   branch_addr
);

  localparam int ext_w = mips_pkg::data_w - 18; // sign bits above offset << 2.

  logic [mips_pkg::data_w-1:0] pc_plus_4;
  logic [mips_pkg::data_w-1:0] offset_sll2;
  logic [mips_pkg::data_w-1:0] jump_target;
  logic [mips_pkg::data_w-1:0] rel_target;
  logic signed [mips_pkg::data_w-1:0] rs_s;
  logic                        taken;
  logic [mips_pkg::data_w-1:0] target;

  // ~~~~~~~~~~~~~~~~~~~~
  // targets
  // ~~~~~~~~~~~~~~~~~~~~

  assign pc_plus_4   = pc + 32'd4;
  assign offset_sll2 = {{ext_w{inst[15]}}, inst[15:0], 2'b00};
  assign rel_target  = pc_plus_4 + offset_sll2;

  // stays inside the 256 MB region of the delay slot.
  assign jump_target = {pc_plus_4[mips_pkg::data_w-1:mips_pkg::data_w-4], inst[25:0], 2'b00};

  assign rs_s = $signed(rs_data);

  // ~~~~~~~~~~~~~~~~~~~~
  // condition
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    taken  = 1'b0;
    target = rel_target;

    case (branch_kind)
      mips_pkg::br_jump: begin
        taken  = 1'b1;
        target = jump_target;
      end
      mips_pkg::br_jreg: begin
        taken  = 1'b1;
        target = rs_data;
      end
      mips_pkg::br_eq: begin
        taken = (rs_data == rt_data);
      end
      mips_pkg::br_ne: begin
        taken = (rs_data != rt_data);
      end
      mips_pkg::br_gtz: begin
        taken = (rs_s > 0);
      end
      mips_pkg::br_lez: begin
        taken = (rs_s <= 0);
      end
      mips_pkg::br_ltz: begin
        taken = (rs_s < 0);
      end
      mips_pkg::br_gez: begin
        taken = (rs_s >= 0);
      end
      default: begin
        taken = 1'b0;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // outputs
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    branch_flag = taken;
    branch_addr = taken ? target : '0; // zero when falling through.

    // pc_reg relies on a clean zero when not taken.
    assert (branch_flag || branch_addr == '0)
      else $error("branch_gen: target %h with no branch", branch_addr);
  end

endmodule

// File: hw/pc_reg.sv
module pc_reg #(
  parameter logic [mips_pkg::data_w-1:0] RESET_VECTOR = 32'hbfc0_0000
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          branch_flag,
  input  logic [mips_pkg::data_w-1:0]   branch_addr,
  output logic [mips_pkg::data_w-1:0]   pc,
  output logic [mips_pkg::data_w-1:0]   link_data
);

  logic [mips_pkg::data_w-1:0] pc_seq;
  logic [mips_pkg::data_w-1:0] pc_next;

  // ~~~~~~~~~~~~~~~~~~~~
  // next pc
  // ~~~~~~~~~~~~~~~~~~~~

  assign pc_seq  = pc + 32'd4;
  assign pc_next = branch_flag ? branch_addr : pc_seq; // no delay slot modelled.

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_VECTOR;
    end else begin
      pc <= pc_next;
    end
  end

  // return address skips the delay slot.
  assign link_data = pc + 32'd8;

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~

  // targets come from registers too, so alignment is not guaranteed locally.
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("pc_reg: unaligned pc %h", pc);

endmodule

// File: hw/branch_unit_top.sv
module branch_unit_top #(
  parameter logic [mips_pkg::data_w-1:0] RESET_VECTOR = 32'hbfc0_0000
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [31:0]                       inst,
  input  logic                              wr_en,
  input  logic [mips_pkg::reg_addr_w-1:0]   wr_addr,
  input  logic [mips_pkg::data_w-1:0]       wr_data,
  output logic [mips_pkg::data_w-1:0]       pc,
  output logic                              branch_flag,
  output logic [mips_pkg::data_w-1:0]       branch_addr
);

  mips_pkg::branch_kind_t          branch_kind;
  logic                            link_en;
  logic [mips_pkg::reg_addr_w-1:0] link_addr;
  logic [mips_pkg::data_w-1:0]     link_data;
  logic [mips_pkg::data_w-1:0]     rs_data;
  logic [mips_pkg::data_w-1:0]     rt_data;

  // ~~~~~~~~~~~~~~~~~~~~
  // decode and operands
  // ~~~~~~~~~~~~~~~~~~~~

  branch_decoder decoder0 (
    .inst        (inst),
    .branch_kind (branch_kind),
    .link_en     (link_en),
    .link_addr   (link_addr)
  );

  reg_file regs0 (
    .clk       (clk),
    .rst       (rst),
    .rs_addr   (inst[25:21]),
    .rt_addr   (inst[20:16]),
    .rs_data   (rs_data),
    .rt_data   (rt_data),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .link_en   (link_en),
    .link_addr (link_addr),
    .link_data (link_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // resolve and advance
  // ~~~~~~~~~~~~~~~~~~~~

  branch_gen gen0 (
    .pc          (pc),
    .inst        (inst),
    .branch_kind (branch_kind),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .branch_flag (branch_flag),
    .branch_addr (branch_addr)
  );

  pc_reg #(
    .RESET_VECTOR (RESET_VECTOR)
  ) pc0 (
    .clk         (clk),
    .rst         (rst),
    .branch_flag (branch_flag),
    .branch_addr (branch_addr),
    .pc          (pc),
    .link_data   (link_data)
  );

endmodule

// File: bench/branch_unit_tb.sv
module branch_unit_tb;

  localparam logic [31:0] reset_vector = 32'h0040_0000;
  localparam int n_preload   = 9;
  localparam int n_tests     = 30;
  localparam int cycle_limit = n_preload + n_tests + 4 + 20;
  localparam logic [31:0] nop = 32'h0000_0000;

  logic        clk;
  logic        rst;
  logic [31:0] inst;
  logic        wr_en;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;
  logic [31:0] pc;
  logic        branch_flag;
  logic [31:0] branch_addr;

  logic [4:0]  pre_addr [n_preload];
  logic [31:0] pre_data [n_preload];
  string       t_name   [n_tests];
  logic [31:0] t_inst   [n_tests];
  logic [31:0] t_pc     [n_tests]; // pc expected before the entry.
  logic        t_wen    [n_tests];
  logic [4:0]  t_waddr  [n_tests];
  logic [31:0] t_wdata  [n_tests];
  logic [31:0] model_regs [32];

  integer seed;
  int     n_added;
  int     cycle_count;
  int     errors;
  int     tests_run;
  int     failed_tests;
  bit     test_ok;

  branch_unit_top #(
    .RESET_VECTOR (reset_vector)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .inst        (inst),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .pc          (pc),
    .branch_flag (branch_flag),
    .branch_addr (branch_addr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // encoders
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rd,
                                        input logic [5:0] funct);
    return {6'h00, rs, 5'd0, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]}; // index within the current region.
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic model_branch(input logic [31:0] ins, input logic [31:0] cur_pc,
                              output logic taken, output logic [31:0] target,
                              output logic link, output logic [4:0] laddr);
    logic signed [31:0] rs_v;
    logic [31:0]        rt_v;
    logic [31:0]        pc4;
    logic [31:0]        rel;
    rs_v   = model_regs[ins[25:21]];
    rt_v   = model_regs[ins[20:16]];
    pc4    = cur_pc + 32'd4;
    rel    = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
    taken  = 1'b0;
    target = rel;
    link   = 1'b0;
    laddr  = 5'd31;
    case (ins[31:26])
      6'h02, 6'h03: begin
        taken  = 1'b1;
        target = {pc4[31:28], ins[25:0], 2'b00};
        link   = (ins[31:26] == 6'h03);
      end
      6'h00: begin
        if (ins[5:0] == 6'h08 || ins[5:0] == 6'h09) begin
          taken  = 1'b1;
          target = rs_v;
          link   = (ins[5:0] == 6'h09);
          laddr  = ins[15:11]; // jalr names its own link register.
        end
      end
      6'h04: taken = (rs_v == rt_v);
      6'h05: taken = (rs_v != rt_v);
      6'h06: taken = (rs_v <= 0);
      6'h07: taken = (rs_v > 0);
      6'h01: begin
        case (ins[20:16])
          5'h00, 5'h10: taken = (rs_v < 0);
          5'h01, 5'h11: taken = (rs_v >= 0);
          default: taken = 1'b0;
        endcase
        link = (ins[20:16] == 5'h10 || ins[20:16] == 5'h11);
      end
      default: taken = 1'b0;
    endcase
    if (!taken) begin
      target = 32'd0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // checking
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check(input string name, input string what,
                       input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic report(input string name);
    tests_run++;
    if (test_ok) begin
      $display("%-18s ok", name);
    end else begin
      $display("%-18s failed", name);
      failed_tests++;
    end
  endtask

  task automatic add_test(input string name, input logic [31:0] ins,
                          input logic [31:0] pc_before, input logic we,
                          input logic [4:0] wa, input logic [31:0] wd);
    t_name[n_added]  = name;
    t_inst[n_added]  = ins;
    t_pc[n_added]    = pc_before;
    t_wen[n_added]   = we;
    t_waddr[n_added] = wa;
    t_wdata[n_added] = wd;
    n_added++;
  endtask

  task automatic build_tables();
    seed = 89815;
    pre_addr[0] = 5'd1;
    pre_data[0] = 32'h0000_0005;
    pre_addr[1] = 5'd2;
    pre_data[1] = 32'h0000_0005; // equal to r1.
    pre_addr[2] = 5'd3;
    pre_data[2] = 32'hffff_fff6; // -10.
    pre_addr[3] = 5'd4;
    pre_data[3] = 32'h0000_0000;
    pre_addr[4] = 5'd5;
    pre_data[4] = 32'h8000_0000;
    pre_addr[5] = 5'd6;
    pre_data[5] = 32'h7fff_ffff;
    pre_addr[6] = 5'd8;
    pre_data[6] = 32'h0040_0300; // jalr target.
    pre_addr[7] = 5'd9;
    pre_data[7] = $random(seed);
    pre_addr[8] = 5'd10;
    pre_data[8] = $random(seed);
    n_added = 0;
    add_test("nop_a",           nop,                            32'h0040_0024, 0, 0, 0);
    add_test("nop_b",           nop,                            32'h0040_0028, 0, 0, 0);
    add_test("j_fwd",           enc_j(6'h02, 32'h0040_0100),    32'h0040_002c, 0, 0, 0);
    add_test("jal",             enc_j(6'h03, 32'h0040_0200),    32'h0040_0100, 0, 0, 0);
    add_test("jr_ra_jal",       enc_r(5'd31, 5'd0, 6'h08),      32'h0040_0200, 0, 0, 0);
    add_test("jalr_r7",         enc_r(5'd8, 5'd7, 6'h09),       32'h0040_0108, 0, 0, 0);
    add_test("jr_r7",           enc_r(5'd7, 5'd0, 6'h08),       32'h0040_0300, 0, 0, 0);
    add_test("beq_taken_fwd",   enc_i(6'h04, 1, 2, 16'h0004),   32'h0040_0110, 0, 0, 0);
    add_test("beq_not_taken",   enc_i(6'h04, 1, 3, 16'h0004),   32'h0040_0124, 0, 0, 0);
    add_test("bne_taken_back",  enc_i(6'h05, 1, 3, 16'hfff8),   32'h0040_0128, 0, 0, 0);
    add_test("bne_not_taken",   enc_i(6'h05, 1, 2, 16'hfff8),   32'h0040_010c, 0, 0, 0);
    // the two random words differ, so beq falls through and bne is taken.
    add_test("beq_rand_pair",   enc_i(6'h04, 9, 10, 16'h0002),  32'h0040_0110, 0, 0, 0);
    add_test("bne_rand_pair",   enc_i(6'h05, 10, 9, 16'h0002),  32'h0040_0114, 0, 0, 0);
    add_test("bgtz_neg",        enc_i(6'h07, 3, 0, 16'h0004),   32'h0040_0120, 0, 0, 0);
    add_test("bgtz_zero",       enc_i(6'h07, 4, 0, 16'h0004),   32'h0040_0124, 0, 0, 0);
    add_test("bgtz_pos",        enc_i(6'h07, 1, 0, 16'h0004),   32'h0040_0128, 0, 0, 0);
    add_test("blez_neg",        enc_i(6'h06, 5, 0, 16'h0004),   32'h0040_013c, 0, 0, 0);
    add_test("blez_zero",       enc_i(6'h06, 4, 0, 16'hfffc),   32'h0040_0150, 0, 0, 0);
    add_test("blez_pos",        enc_i(6'h06, 6, 0, 16'h0004),   32'h0040_0144, 0, 0, 0);
    add_test("bltz_neg",        enc_i(6'h01, 3, 0, 16'h0002),   32'h0040_0148, 0, 0, 0);
    add_test("bltz_zero",       enc_i(6'h01, 4, 0, 16'h0002),   32'h0040_0154, 0, 0, 0);
    add_test("bgez_zero",       enc_i(6'h01, 4, 1, 16'h0002),   32'h0040_0158, 0, 0, 0);
    add_test("bgez_neg",        enc_i(6'h01, 5, 1, 16'h0002),   32'h0040_0164, 0, 0, 0);
    add_test("bgez_pos",        enc_i(6'h01, 6, 1, 16'hfffe),   32'h0040_0168, 0, 0, 0);
    add_test("bltzal_not",      enc_i(6'h01, 1, 16, 16'h0004),  32'h0040_0164, 0, 0, 0);
    add_test("jr_ra_bltzal",    enc_r(5'd31, 5'd0, 6'h08),      32'h0040_0168, 0, 0, 0);
    // external write to r31 collides with the link write.
    add_test("bgezal_clash",    enc_i(6'h01, 1, 17, 16'h0004),  32'h0040_016c, 1, 31,
             32'hdead_beec);
    add_test("jr_ra_clash",     enc_r(5'd31, 5'd0, 6'h08),      32'h0040_0180, 0, 0, 0);
    add_test("write_r0",        nop,                            32'h0040_0174, 1, 0,
             32'h1234_5678);
    // r4 holds zero, so this stays taken only while r0 still reads zero.
    add_test("beq_r0_r4",       enc_i(6'h04, 0, 4, 16'h0001),   32'h0040_0178, 0, 0, 0);
  endtask

  task automatic run_test(input int t);
    logic        exp_taken;
    logic        exp_link;
    logic [4:0]  exp_laddr;
    logic [31:0] exp_target;
    logic [31:0] exp_next;
    test_ok = 1'b1;
    inst    = t_inst[t];
    wr_en   = t_wen[t];
    wr_addr = t_waddr[t];
    wr_data = t_wdata[t];
    model_branch(t_inst[t], t_pc[t], exp_taken, exp_target, exp_link, exp_laddr);
    exp_next = exp_taken ? exp_target : t_pc[t] + 32'd4;
    #5; // outputs settle by mid low phase.
    check(t_name[t], "pc", t_pc[t], pc);
    check(t_name[t], "branch_flag", {31'd0, exp_taken}, {31'd0, branch_flag});
    check(t_name[t], "branch_addr", exp_target, branch_addr);
    @(negedge clk);
    check(t_name[t], "next pc", exp_next, pc);
    if (t_wen[t] && t_waddr[t] != 5'd0) begin
      model_regs[t_waddr[t]] = t_wdata[t];
    end
    if (exp_link && exp_laddr != 5'd0) begin
      model_regs[exp_laddr] = t_pc[t] + 32'd8; // link lands last.
    end
    report(t_name[t]);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    inst         = nop;
    wr_en        = 1'b0;
    wr_addr      = 5'd0;
    wr_data      = 32'd0;
    cycle_count  = 0;
    errors       = 0;
    tests_run    = 0;
    failed_tests = 0;
    build_tables();
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = 32'd0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_ok = 1'b1;
    check("reset_vector", "pc", reset_vector, pc);
    report("reset_vector");
    for (int p = 0; p < n_preload; p++) begin
      wr_en   = 1'b1;
      wr_addr = pre_addr[p];
      wr_data = pre_data[p];
      model_regs[pre_addr[p]] = pre_data[p];
      @(negedge clk);
    end
    wr_en = 1'b0;
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d failed, %0d mismatches", tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/mips_pkg.sv
hw/branch_decoder.sv
hw/reg_file.sv
hw/branch_gen.sv
hw/pc_reg.sv
hw/branch_unit_top.sv
bench/branch_unit_tb.sv

// File: Bender.yml
package:
  name: branch_unit

sources:
  # package first, then leaf modules, then the top level.
  - hw/mips_pkg.sv
  - hw/branch_decoder.sv
  - hw/reg_file.sv
  - hw/branch_gen.sv
  - hw/pc_reg.sv
  - hw/branch_unit_top.sv

  - target: simulation
    files:
      - bench/branch_unit_tb.sv
